/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= board_io_tb
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := === FAIL ===

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove build output and the log"

# A simulator that exits with an error also counts as a failed run
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: failed"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
logic/io_pkg.sv
logic/io_decode.sv
logic/gpio_port.sv
logic/tim0_counter.sv
logic/data_ram.sv
logic/read_mux.sv
logic/board_io_top.sv
tb/board_io_asserts.sv
tb/board_io_tb.sv

/* logic/board_io_top.sv */
/* I/O side of the game board: bus decode, ports B-F, timer 0 and data RAM.
   RGB LED is common anode, so a 1 on rgb means that LED is off. */
module board_io_top #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [io_pkg::BUS_ADDR_WIDTH-1:0] data_addr,
    input  logic [io_pkg::DATA_WIDTH-1:0]     data_wdata,
    input  logic                              data_write,
    input  logic                              data_read,
    output logic [io_pkg::DATA_WIDTH-1:0]     data_rdata,
    output logic                              rd_valid,
    input  logic [5:0]                        buttons,
    output logic [2:0]                        rgb,
    output logic                              buzzer1,
    output logic                              dc
);

    io_pkg::target_e   target;
    io_pkg::port_reg_e port_reg;
    io_pkg::tim_reg_e  tim_reg;
    logic ram_we, port_b_we, port_c_we, port_d_we, tim0_we;
    logic [7:0] pb_in, pe_in, pf_in;
    logic [7:0] pb_out, pc_out, pd_out;
    logic [7:0] ram_rdata, pb_rdata, pc_rdata, pd_rdata, pe_rdata, pf_rdata, tim0_rdata;
    logic oc0a, oc0a_en;

    // Button pins
    assign pb_in = {3'b000, buttons[5], 4'b0000};                      // B on PB4
    assign pe_in = {1'b0, buttons[4], 6'b000000};                      // A on PE6
    assign pf_in = {buttons[3], buttons[0], buttons[1], buttons[2], 4'b0000}; // Up, right, left, down

    io_decode u_decode (
        .data_addr(data_addr), .data_write(data_write), .target(target),
        .port_reg(port_reg), .tim_reg(tim_reg), .ram_we(ram_we), .port_b_we(port_b_we),
        .port_c_we(port_c_we), .port_d_we(port_d_we), .tim0_we(tim0_we)
    );

    gpio_port #(.WRITABLE(1'b1), .PIN_MASK(8'hF0), .INVERT_MASK(8'h10), .OUT_MASK(8'hEF)) port_b (
        .clk(clk), .rst(rst), .we(port_b_we), .reg_sel(port_reg), .wdata(data_wdata),
        .pin_in(pb_in), .rdata(pb_rdata), .pin_out(pb_out)
    );

    gpio_port #(.WRITABLE(1'b1), .PIN_MASK(8'hC0), .INVERT_MASK(8'h00), .OUT_MASK(8'hC0)) port_c (
        .clk(clk), .rst(rst), .we(port_c_we), .reg_sel(port_reg), .wdata(data_wdata),
        .pin_in(8'h00), .rdata(pc_rdata), .pin_out(pc_out)
    );

    gpio_port #(.WRITABLE(1'b1), .PIN_MASK(8'hD0), .INVERT_MASK(8'h00), .OUT_MASK(8'hFF)) port_d (
        .clk(clk), .rst(rst), .we(port_d_we), .reg_sel(port_reg), .wdata(data_wdata),
        .pin_in(8'h00), .rdata(pd_rdata), .pin_out(pd_out)
    );

    // Input only ports
    gpio_port #(.WRITABLE(1'b0), .PIN_MASK(8'h40), .INVERT_MASK(8'h40), .OUT_MASK(8'h00)) port_e (
        .clk(clk), .rst(rst), .we(1'b0), .reg_sel(port_reg), .wdata(data_wdata),
        .pin_in(pe_in), .rdata(pe_rdata), .pin_out()
    );

    gpio_port #(.WRITABLE(1'b0), .PIN_MASK(8'hF3), .INVERT_MASK(8'hF0), .OUT_MASK(8'h00)) port_f (
        .clk(clk), .rst(rst), .we(1'b0), .reg_sel(port_reg), .wdata(data_wdata),
        .pin_in(pf_in), .rdata(pf_rdata), .pin_out()
    );

    tim0_counter u_tim0 (
        .clk(clk), .rst(rst), .we(tim0_we), .reg_sel(tim_reg), .wdata(data_wdata),
        .rdata(tim0_rdata), .oc0a(oc0a), .oc0a_en(oc0a_en)
    );

    data_ram #(.ADDR_WIDTH(RAM_ADDR_WIDTH)) u_ram (
        .clk(clk), .we(ram_we), .re(data_read && (target == io_pkg::tgt_ram)),
        .addr(data_addr[RAM_ADDR_WIDTH-1:0]), .wdata(data_wdata), .rdata(ram_rdata)
    );

    read_mux u_read_mux (
        .clk(clk), .rst(rst), .read(data_read), .target(target), .ram_rdata(ram_rdata),
        .port_b_rdata(pb_rdata), .port_c_rdata(pc_rdata), .port_d_rdata(pd_rdata),
        .port_e_rdata(pe_rdata), .port_f_rdata(pf_rdata), .tim0_rdata(tim0_rdata),
        .rdata(data_rdata), .rd_valid(rd_valid)
    );

    assign rgb[2]  = ~pb_out[6];                        // Blue
    assign rgb[1]  = oc0a_en ? ~oc0a : ~pb_out[7];      // Green, timer 0 takes over
    assign rgb[0]  = ~pb_out[5];                        // Red
    assign buzzer1 = pc_out[6];
    assign dc      = pd_out[4];                         // Display data/command

endmodule

/* logic/data_ram.sv */
/* Byte RAM, write and read both registered.
   Output holds its last value while re is low. */
module data_ram #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic                          re,
    input  logic [ADDR_WIDTH-1:0]         addr,
    input  logic [io_pkg::DATA_WIDTH-1:0] wdata,
    output logic [io_pkg::DATA_WIDTH-1:0] rdata
);

    logic [io_pkg::DATA_WIDTH-1:0] mem [0:(2**ADDR_WIDTH)-1];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        if (re)
            rdata <= mem[addr]; // Read and write never share a cycle
    end

endmodule

/* logic/gpio_port.sv */
/* One 8-bit port. With WRITABLE at 0 the PORT and DDR registers stay 0.
   PIN reads the raw pins only, never the driven outputs. */
module gpio_port #(
    parameter bit         WRITABLE    = 1'b1,
    parameter logic [7:0] PIN_MASK    = 8'hFF,
    parameter logic [7:0] INVERT_MASK = 8'h00,
    parameter logic [7:0] OUT_MASK    = 8'hFF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  io_pkg::port_reg_e             reg_sel,
    input  logic [io_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] pin_in,
    output logic [io_pkg::DATA_WIDTH-1:0] rdata,
    output logic [io_pkg::DATA_WIDTH-1:0] pin_out
);

    logic [io_pkg::DATA_WIDTH-1:0] port_q;
    logic [io_pkg::DATA_WIDTH-1:0] ddr_q;
    logic [io_pkg::DATA_WIDTH-1:0] pin_val;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            port_q <= '0;
            ddr_q  <= '0;
        end
        else if (WRITABLE && we)
        begin
            if (reg_sel == io_pkg::preg_port)
                port_q <= wdata;
            if (reg_sel == io_pkg::preg_ddr)
                ddr_q <= wdata;
            // Writes to PIN are ignored
        end
    end

    // Buttons are active low on some pins
    assign pin_val = (pin_in ^ INVERT_MASK) & PIN_MASK;

    // Only driven when set as output
    assign pin_out = port_q & ddr_q & OUT_MASK;

    always_comb
    begin
        case (reg_sel)
            io_pkg::preg_ddr:  rdata = ddr_q;
            io_pkg::preg_port: rdata = port_q;
            default:           rdata = pin_val;
        endcase
    end

endmodule

/* logic/io_decode.sv */
/* Combinational bus decode. Only PIN exists for ports E and F,
   so their other addresses read as unmapped. */
module io_decode (
    input  logic [io_pkg::BUS_ADDR_WIDTH-1:0] data_addr,
    input  logic                              data_write,
    output io_pkg::target_e                   target,
    output io_pkg::port_reg_e                 port_reg,
    output io_pkg::tim_reg_e                  tim_reg,
    output logic                              ram_we,
    output logic                              port_b_we,
    output logic                              port_c_we,
    output logic                              port_d_we,
    output logic                              tim0_we
);

    always_comb
    begin
        target   = io_pkg::tgt_none;
        port_reg = io_pkg::preg_pin;
        tim_reg  = io_pkg::treg_tifr;
        if (data_addr >= io_pkg::IO_SPACE_TOP)
        begin
            target = io_pkg::tgt_ram;
        end
        else
        begin
            case (data_addr)
                io_pkg::PINB_ADDR:   target = io_pkg::tgt_port_b;
                io_pkg::DDRB_ADDR:   begin target = io_pkg::tgt_port_b; port_reg = io_pkg::preg_ddr; end
                io_pkg::PORTB_ADDR:  begin target = io_pkg::tgt_port_b; port_reg = io_pkg::preg_port; end
                io_pkg::PINC_ADDR:   target = io_pkg::tgt_port_c;
                io_pkg::DDRC_ADDR:   begin target = io_pkg::tgt_port_c; port_reg = io_pkg::preg_ddr; end
                io_pkg::PORTC_ADDR:  begin target = io_pkg::tgt_port_c; port_reg = io_pkg::preg_port; end
                io_pkg::PIND_ADDR:   target = io_pkg::tgt_port_d;
                io_pkg::DDRD_ADDR:   begin target = io_pkg::tgt_port_d; port_reg = io_pkg::preg_ddr; end
                io_pkg::PORTD_ADDR:  begin target = io_pkg::tgt_port_d; port_reg = io_pkg::preg_port; end
                io_pkg::PINE_ADDR:   target = io_pkg::tgt_port_e;
                io_pkg::PINF_ADDR:   target = io_pkg::tgt_port_f;
                io_pkg::TIFR0_ADDR:  target = io_pkg::tgt_tim0;
                io_pkg::TCCR0A_ADDR: begin target = io_pkg::tgt_tim0; tim_reg = io_pkg::treg_tccra; end
                io_pkg::TCCR0B_ADDR: begin target = io_pkg::tgt_tim0; tim_reg = io_pkg::treg_tccrb; end
                io_pkg::TCNT0_ADDR:  begin target = io_pkg::tgt_tim0; tim_reg = io_pkg::treg_tcnt; end
                io_pkg::OCR0A_ADDR:  begin target = io_pkg::tgt_tim0; tim_reg = io_pkg::treg_ocra; end
                default:             target = io_pkg::tgt_none; // Unmapped, reads 0
            endcase
        end
    end

    // One strobe per writable target
    assign ram_we    = data_write && (target == io_pkg::tgt_ram);
    assign port_b_we = data_write && (target == io_pkg::tgt_port_b);
    assign port_c_we = data_write && (target == io_pkg::tgt_port_c);
    assign port_d_we = data_write && (target == io_pkg::tgt_port_d);
    assign tim0_we   = data_write && (target == io_pkg::tgt_tim0);

endmodule

/* logic/io_pkg.sv */
/* Shared widths, I/O register map and enums of the board I/O block.
   Addresses are full bus addresses; RAM starts at IO_SPACE_TOP. */
package io_pkg;

    localparam int BUS_ADDR_WIDTH = 12;
    localparam int DATA_WIDTH     = 8;

    localparam logic [BUS_ADDR_WIDTH-1:0] IO_SPACE_TOP = 12'h100;

    localparam logic [BUS_ADDR_WIDTH-1:0] PINB_ADDR   = 12'h023;
    localparam logic [BUS_ADDR_WIDTH-1:0] DDRB_ADDR   = 12'h024;
    localparam logic [BUS_ADDR_WIDTH-1:0] PORTB_ADDR  = 12'h025;
    localparam logic [BUS_ADDR_WIDTH-1:0] PINC_ADDR   = 12'h026;
    localparam logic [BUS_ADDR_WIDTH-1:0] DDRC_ADDR   = 12'h027;
    localparam logic [BUS_ADDR_WIDTH-1:0] PORTC_ADDR  = 12'h028;
    localparam logic [BUS_ADDR_WIDTH-1:0] PIND_ADDR   = 12'h029;
    localparam logic [BUS_ADDR_WIDTH-1:0] DDRD_ADDR   = 12'h02A;
    localparam logic [BUS_ADDR_WIDTH-1:0] PORTD_ADDR  = 12'h02B;
    localparam logic [BUS_ADDR_WIDTH-1:0] PINE_ADDR   = 12'h02C;
    localparam logic [BUS_ADDR_WIDTH-1:0] PINF_ADDR   = 12'h02F;
    localparam logic [BUS_ADDR_WIDTH-1:0] TIFR0_ADDR  = 12'h035;
    localparam logic [BUS_ADDR_WIDTH-1:0] TCCR0A_ADDR = 12'h044;
    localparam logic [BUS_ADDR_WIDTH-1:0] TCCR0B_ADDR = 12'h045;
    localparam logic [BUS_ADDR_WIDTH-1:0] TCNT0_ADDR  = 12'h046;
    localparam logic [BUS_ADDR_WIDTH-1:0] OCR0A_ADDR  = 12'h047;

    typedef enum logic [2:0] {
        tgt_none, tgt_ram, tgt_port_b, tgt_port_c,
        tgt_port_d, tgt_port_e, tgt_port_f, tgt_tim0
    } target_e;

    typedef enum logic [1:0] {preg_pin, preg_ddr, preg_port} port_reg_e;

    typedef enum logic [2:0] {treg_tifr, treg_tccra, treg_tccrb, treg_tcnt, treg_ocra} tim_reg_e;

    // TCCR0B[2:0], codes 6 and 7 behave as stop
    typedef enum logic [2:0] {
        cs_stop = 3'd0, cs_div1 = 3'd1, cs_div8 = 3'd2,
        cs_div64 = 3'd3, cs_div256 = 3'd4, cs_div1024 = 3'd5
    } clk_sel_e;

    localparam int TOV0_BIT  = 0;
    localparam int OCF0A_BIT = 1;

    localparam logic [1:0] COM0A_TOGGLE = 2'd1; // TCCR0A[7:6]

endpackage

/* logic/read_mux.sv */
/* Read-data return with one cycle latency and a rd_valid pulse.
   rdata holds until the next read. */
module read_mux (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          read,
    input  io_pkg::target_e               target,
    input  logic [io_pkg::DATA_WIDTH-1:0] ram_rdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] port_b_rdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] port_c_rdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] port_d_rdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] port_e_rdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] port_f_rdata,
    input  logic [io_pkg::DATA_WIDTH-1:0] tim0_rdata,
    output logic [io_pkg::DATA_WIDTH-1:0] rdata,
    output logic                          rd_valid
);

    logic [io_pkg::DATA_WIDTH-1:0] io_sel;
    logic [io_pkg::DATA_WIDTH-1:0] io_q;
    io_pkg::target_e               tgt_q;

    always_comb
    begin
        case (target)
            io_pkg::tgt_port_b: io_sel = port_b_rdata;
            io_pkg::tgt_port_c: io_sel = port_c_rdata;
            io_pkg::tgt_port_d: io_sel = port_d_rdata;
            io_pkg::tgt_port_e: io_sel = port_e_rdata;
            io_pkg::tgt_port_f: io_sel = port_f_rdata;
            io_pkg::tgt_tim0:   io_sel = tim0_rdata;
            default:            io_sel = '0; // RAM path comes from data_ram
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            io_q     <= '0;
            tgt_q    <= io_pkg::tgt_none;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= read;
            if (read)
            begin
                io_q  <= io_sel;
                tgt_q <= target;
            end
        end
    end

    // RAM output is already registered inside data_ram
    assign rdata = (tgt_q == io_pkg::tgt_ram) ? ram_rdata : io_q;

endmodule

/* logic/tim0_counter.sv */
/* Timer 0 in normal mode only, no PWM and no compare B.
   A TCNT0 write at a tick edge wins; that tick neither counts, compares nor sets flags. */
module tim0_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  io_pkg::tim_reg_e              reg_sel,
    input  logic [io_pkg::DATA_WIDTH-1:0] wdata,
    output logic [io_pkg::DATA_WIDTH-1:0] rdata,
    output logic                          oc0a,
    output logic                          oc0a_en
);

    logic [9:0]               presc;
    logic [7:0]               tccr0a;
    logic [7:0]               tccr0b;
    logic [7:0]               tcnt0;
    logic [7:0]               ocr0a;
    logic                     tov0;
    logic                     ocf0a;
    logic [7:0]               tifr0;
    io_pkg::clk_sel_e         clk_sel;
    logic                     tick;
    logic                     tcnt_wr;
    logic                     step;
    logic                     match;
    logic                     wrap;
    logic [1:0]               tifr_clr;

    assign clk_sel = io_pkg::clk_sel_e'(tccr0b[2:0]);

    always_comb
    begin
        case (clk_sel)
            io_pkg::cs_div1:    tick = 1'b1;
            io_pkg::cs_div8:    tick = &presc[2:0];
            io_pkg::cs_div64:   tick = &presc[5:0];
            io_pkg::cs_div256:  tick = &presc[7:0];
            io_pkg::cs_div1024: tick = &presc[9:0];
            default:            tick = 1'b0; // Stopped, also codes 6 and 7
        endcase
    end

    assign tcnt_wr = we && (reg_sel == io_pkg::treg_tcnt);
    assign step    = tick && !tcnt_wr;
    assign match   = (tcnt0 == ocr0a);
    assign wrap    = (tcnt0 == 8'hFF);

    // Write one to clear
    assign tifr_clr[io_pkg::TOV0_BIT]  = we && (reg_sel == io_pkg::treg_tifr) && wdata[io_pkg::TOV0_BIT];
    assign tifr_clr[io_pkg::OCF0A_BIT] = we && (reg_sel == io_pkg::treg_tifr) && wdata[io_pkg::OCF0A_BIT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            presc  <= '0;
            tccr0a <= '0;
            tccr0b <= '0;
            tcnt0  <= '0;
            ocr0a  <= '0;
            tov0   <= 1'b0;
            ocf0a  <= 1'b0;
            oc0a   <= 1'b0;
        end
        else
        begin
            presc <= presc + 10'd1; // Free running
            if (we && reg_sel == io_pkg::treg_tccra)
                tccr0a <= wdata;
            if (we && reg_sel == io_pkg::treg_tccrb)
                tccr0b <= wdata;
            if (we && reg_sel == io_pkg::treg_ocra)
                ocr0a <= wdata;
            if (tcnt_wr)
                tcnt0 <= wdata;
            else if (step)
                tcnt0 <= tcnt0 + 8'd1;
            // Set beats clear in the same edge
            tov0  <= (step && wrap) || (tov0 && !tifr_clr[io_pkg::TOV0_BIT]);
            ocf0a <= (step && match) || (ocf0a && !tifr_clr[io_pkg::OCF0A_BIT]);
            if (step && match && tccr0a[7:6] == io_pkg::COM0A_TOGGLE)
                oc0a <= ~oc0a;
        end
    end

    assign oc0a_en = |tccr0a[7:6];

    always_comb
    begin
        tifr0 = '0;
        tifr0[io_pkg::TOV0_BIT]  = tov0;
        tifr0[io_pkg::OCF0A_BIT] = ocf0a;
        case (reg_sel)
            io_pkg::treg_tccra: rdata = tccr0a;
            io_pkg::treg_tccrb: rdata = tccr0b;
            io_pkg::treg_tcnt:  rdata = tcnt0;
            io_pkg::treg_ocra:  rdata = ocr0a;
            default:            rdata = tifr0;
        endcase
    end

endmodule

/* tb/board_io_asserts.sv */
/* Concurrent checks on bus strobes and read timing, bound into board_io_top.
   Only active with assertions enabled in the simulator. */
module board_io_asserts (
    input logic       clk,
    input logic       rst,
    input logic       data_write,
    input logic       data_read,
    input logic       rd_valid,
    input logic [2:0] rgb
);

    // Fixed one cycle read latency
    rd_valid_follows_read: assert property (
        @(posedge clk) disable iff (rst) !$past(rst) |-> rd_valid == $past(data_read)
    ) else $error("rd_valid does not follow the read strobe of the previous cycle");

    no_read_write_overlap: assert property (
        @(posedge clk) disable iff (rst) !(data_write && data_read)
    ) else $error("read and write strobes high in the same cycle");

    // Common anode LED, so all off right out of reset
    rgb_off_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> rgb == 3'b111
    ) else $error("rgb not all ones in the first cycle after reset");

endmodule

bind board_io_top board_io_asserts u_asserts (
    .clk(clk), .rst(rst), .data_write(data_write), .data_read(data_read),
    .rd_valid(rd_valid), .rgb(rgb)
);

/* tb/board_io_tb.sv */
/* Random bus traffic against a cycle model of the board I/O block.
   Read data is checked one cycle after each read, pins every cycle. */
module board_io_tb;

    localparam int PLANNED_CYCLES = 3030; // Reset, RAM, ports, buttons, timer, flags, unmapped
    localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

    logic clk, rst, data_write, data_read, rd_valid, buzzer1, dc;
    logic [io_pkg::BUS_ADDR_WIDTH-1:0] data_addr;
    logic [7:0] data_wdata, data_rdata;
    logic [5:0] buttons;
    logic [2:0] rgb;

    logic [31:0] rand_state;
    int          cycle_count;
    logic        model_ready;
    logic [7:0]  exp_rdata;
    logic [7:0]  m_ram [0:4095];
    logic [7:0]  m_port [0:2];       // B, C, D
    logic [7:0]  m_ddr [0:2];
    logic [9:0]  m_presc;
    logic [7:0]  m_tccra, m_tccrb, m_tcnt, m_ocra;
    logic        m_tov, m_ocf, m_oc0a;

    board_io_top #(.RAM_ADDR_WIDTH(12)) dut (
        .clk(clk), .rst(rst), .data_addr(data_addr), .data_wdata(data_wdata),
        .data_write(data_write), .data_read(data_read), .data_rdata(data_rdata),
        .rd_valid(rd_valid), .buttons(buttons), .rgb(rgb), .buzzer1(buzzer1), .dc(dc)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 8; // Low LCG bits have short periods
    endfunction

    function automatic logic tick_due(io_pkg::clk_sel_e sel, logic [9:0] presc);
        case (sel)
            io_pkg::cs_div1:    return 1'b1;
            io_pkg::cs_div8:    return presc[2:0] == 3'b111;
            io_pkg::cs_div64:   return presc[5:0] == 6'h3F;
            io_pkg::cs_div256:  return presc[7:0] == 8'hFF;
            io_pkg::cs_div1024: return presc == 10'h3FF;
            default:            return 1'b0;
        endcase
    endfunction

    // Board wiring: buttons 0-3 on PF6/PF5/PF4/PF7, 4 on PE6, 5 on PB4, all active low
    function automatic logic [7:0] expected_read(logic [11:0] addr);
        if (addr >= io_pkg::IO_SPACE_TOP)
            return m_ram[addr];
        case (addr)
            io_pkg::PINB_ADDR:   return {3'b000, ~buttons[5], 4'h0};
            io_pkg::DDRB_ADDR:   return m_ddr[0];
            io_pkg::PORTB_ADDR:  return m_port[0];
            io_pkg::DDRC_ADDR:   return m_ddr[1];
            io_pkg::PORTC_ADDR:  return m_port[1];
            io_pkg::DDRD_ADDR:   return m_ddr[2];
            io_pkg::PORTD_ADDR:  return m_port[2];
            io_pkg::PINE_ADDR:   return {1'b0, ~buttons[4], 6'h00};
            io_pkg::PINF_ADDR:   return {~buttons[3], ~buttons[0], ~buttons[1], ~buttons[2], 4'h0};
            io_pkg::TIFR0_ADDR:  return {6'h00, m_ocf, m_tov};
            io_pkg::TCCR0A_ADDR: return m_tccra;
            io_pkg::TCCR0B_ADDR: return m_tccrb;
            io_pkg::TCNT0_ADDR:  return m_tcnt;
            io_pkg::OCR0A_ADDR:  return m_ocra;
            default:             return 8'h00; // PINC, PIND and holes
        endcase
    endfunction

    function automatic logic is_mapped(logic [11:0] addr);
        case (addr)
            io_pkg::PINB_ADDR, io_pkg::DDRB_ADDR, io_pkg::PORTB_ADDR,
            io_pkg::PINC_ADDR, io_pkg::DDRC_ADDR, io_pkg::PORTC_ADDR,
            io_pkg::PIND_ADDR, io_pkg::DDRD_ADDR, io_pkg::PORTD_ADDR,
            io_pkg::PINE_ADDR, io_pkg::PINF_ADDR, io_pkg::TIFR0_ADDR,
            io_pkg::TCCR0A_ADDR, io_pkg::TCCR0B_ADDR, io_pkg::TCNT0_ADDR,
            io_pkg::OCR0A_ADDR: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s read %02h, expected %02h",
                               $time, what, got, exp));
    endtask

    task automatic check_pins(input logic [2:0] got_rgb, input logic [2:0] exp_rgb,
                              input logic got_buzzer, input logic exp_buzzer,
                              input logic got_dc, input logic exp_dc);
        if (got_rgb !== exp_rgb || got_buzzer !== exp_buzzer || got_dc !== exp_dc)
            fail_run($sformatf("MISMATCH at %0t: rgb/buzzer1/dc %b/%b/%b, expected %b/%b/%b",
                               $time, got_rgb, got_buzzer, got_dc, exp_rgb, exp_buzzer, exp_dc));
    endtask

    task automatic write_bus(input logic [11:0] addr, input logic [7:0] value);
        data_addr  = addr;
        data_wdata = value;
        data_write = 1'b1;
        @(negedge clk);
        data_write = 1'b0;
    endtask

    task automatic read_and_check(input logic [11:0] addr);
        data_addr = addr;
        data_read = 1'b1;
        @(negedge clk);
        data_read = 1'b0;
        if (rd_valid !== 1'b1)
            fail_run($sformatf("rd_valid missing one cycle after the read of %03h", addr));
        check_byte(data_rdata, exp_rdata, $sformatf("address %03h", addr));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            fail_run($sformatf("timeout: no verdict after %0d cycles", CYCLE_LIMIT));
    end

    // Reference model, advanced once per rising edge
    always @(posedge clk)
    begin : model_step
        logic       counting;
        logic [1:0] clr;
        if (rst)
        begin
            m_port      = '{default: 8'h00};
            m_ddr       = '{default: 8'h00};
            m_presc     = '0;
            m_tccra     = '0;
            m_tccrb     = '0;
            m_tcnt      = '0;
            m_ocra      = '0;
            m_tov       = 1'b0;
            m_ocf       = 1'b0;
            m_oc0a      = 1'b0;
            model_ready = 1'b0;
        end
        else
        begin
            model_ready = 1'b1;
            if (data_read)
                exp_rdata = expected_read(data_addr); // State before this edge
            clr = (data_write && data_addr == io_pkg::TIFR0_ADDR) ? data_wdata[1:0] : 2'b00;
            counting = tick_due(io_pkg::clk_sel_e'(m_tccrb[2:0]), m_presc)
                       && !(data_write && data_addr == io_pkg::TCNT0_ADDR);
            m_tov = (counting && m_tcnt == 8'hFF) || (m_tov && !clr[io_pkg::TOV0_BIT]);
            m_ocf = (counting && m_tcnt == m_ocra) || (m_ocf && !clr[io_pkg::OCF0A_BIT]);
            if (counting && m_tcnt == m_ocra && m_tccra[7:6] == io_pkg::COM0A_TOGGLE)
                m_oc0a = !m_oc0a;
            if (counting)
                m_tcnt = m_tcnt + 8'd1;
            m_presc = m_presc + 10'd1;
            if (data_write)
            begin
                if (data_addr >= io_pkg::IO_SPACE_TOP)
                    m_ram[data_addr] = data_wdata;
                case (data_addr)
                    io_pkg::DDRB_ADDR:   m_ddr[0]  = data_wdata;
                    io_pkg::PORTB_ADDR:  m_port[0] = data_wdata;
                    io_pkg::DDRC_ADDR:   m_ddr[1]  = data_wdata;
                    io_pkg::PORTC_ADDR:  m_port[1] = data_wdata;
                    io_pkg::DDRD_ADDR:   m_ddr[2]  = data_wdata;
                    io_pkg::PORTD_ADDR:  m_port[2] = data_wdata;
                    io_pkg::TCCR0A_ADDR: m_tccra   = data_wdata;
                    io_pkg::TCCR0B_ADDR: m_tccrb   = data_wdata;
                    io_pkg::OCR0A_ADDR:  m_ocra    = data_wdata;
                    io_pkg::TCNT0_ADDR:  m_tcnt    = data_wdata; // Load beats the tick
                    default:             ;
                endcase
            end
        end
    end

    always @(negedge clk)
    begin : pin_compare
        logic [7:0] pb_drv, pc_drv, pd_drv;
        logic [2:0] exp_rgb;
        if (model_ready)
        begin
            pb_drv = m_port[0] & m_ddr[0] & 8'hEF;   // PB4 is a button
            pc_drv = m_port[1] & m_ddr[1] & 8'hC0;
            pd_drv = m_port[2] & m_ddr[2];
            exp_rgb[2] = ~pb_drv[6];
            exp_rgb[1] = (m_tccra[7:6] != 2'b00) ? ~m_oc0a : ~pb_drv[7]; // OC0A owns green
            exp_rgb[0] = ~pb_drv[5];
            check_pins(rgb, exp_rgb, buzzer1, pc_drv[6], dc, pd_drv[4]);
        end
    end

    initial
    begin : stimulus
        logic [11:0] addr;
        logic [11:0] written [$];
        logic [11:0] port_regs [0:5];
        logic [31:0] r;
        logic [2:0]  sel;
        int          i;
        int          k;
        rand_state  = 32'h4b98_03cb;
        cycle_count = 0;
        model_ready = 1'b0;
        clk         = 1'b0;
        rst         = 1'b1;
        data_addr   = '0;
        data_wdata  = '0;
        data_write  = 1'b0;
        data_read   = 1'b0;
        buttons     = '0;
        port_regs = '{io_pkg::DDRB_ADDR, io_pkg::PORTB_ADDR, io_pkg::DDRC_ADDR,
                      io_pkg::PORTC_ADDR, io_pkg::DDRD_ADDR, io_pkg::PORTD_ADDR};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // RAM above the I/O space, reads only from written addresses
        for (i = 0; i < 40; i++)
        begin
            addr = 12'(32'h100 + next_rand() % 32'hF00);
            written.push_back(addr);
            write_bus(addr, 8'(next_rand()));
        end
        for (i = 0; i < 40; i++)
            read_and_check(written[next_rand() % written.size()]);

        for (i = 0; i < 40; i++)
        begin
            sel = 3'(next_rand() % 6);
            write_bus(port_regs[sel], 8'(next_rand()));
            sel = 3'(next_rand() % 6);
            read_and_check(port_regs[sel]);
        end

        // All outputs driven high so PIN reads show they are ignored
        for (sel = 0; sel < 6; sel++)
            write_bus(port_regs[sel], 8'hFF);
        for (i = 0; i < 20; i++)
        begin
            buttons = 6'(next_rand());
            r = next_rand();
            write_bus(r[8] ? 12'h02E : 12'h031, r[7:0]); // PORTE and PORTF spots
            read_and_check(io_pkg::PINB_ADDR);
            read_and_check(io_pkg::PINC_ADDR);
            read_and_check(io_pkg::PIND_ADDR);
            read_and_check(io_pkg::PINE_ADDR);
            read_and_check(io_pkg::PINF_ADDR);
            read_and_check(12'h02E);
            read_and_check(12'h031);
        end

        for (i = 0; i < 2; i++)
        begin
            write_bus(io_pkg::TCNT0_ADDR, 8'(next_rand()));
            write_bus(io_pkg::TCCR0B_ADDR, (i == 0) ? 8'(io_pkg::cs_div1) : 8'(io_pkg::cs_div8));
            for (k = 0; k < 20; k++)
            begin
                idle(int'(next_rand() % 16));
                read_and_check(io_pkg::TCNT0_ADDR);
            end
        end

        // Compare toggle on the green LED, flags cleared by writing ones
        write_bus(io_pkg::OCR0A_ADDR, 8'(next_rand()));
        write_bus(io_pkg::TCCR0A_ADDR, {io_pkg::COM0A_TOGGLE, 6'h00});
        write_bus(io_pkg::TCCR0B_ADDR, 8'(io_pkg::cs_div1));
        for (i = 0; i < 30; i++)
        begin
            idle(int'(next_rand() % 64));
            read_and_check(io_pkg::TIFR0_ADDR);
            write_bus(io_pkg::TIFR0_ADDR, 8'(next_rand() % 4));
            read_and_check(io_pkg::TIFR0_ADDR);
            read_and_check(io_pkg::TCNT0_ADDR);
        end

        for (i = 0; i < 20; i++)
        begin
            addr = 12'(next_rand() % 256);
            if (!is_mapped(addr))
            begin
                write_bus(addr, 8'(next_rand()));
                read_and_check(addr);
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
